// ==== common/imem_pkg.sv ====
/*
 * Instruction memory controller shared definitions
 * Widths, attribute region layout, bus address phase and the
 * parcel entry that travels towards the CPU
 */

package imem_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int XLEN     = 32;  // Address and bus data width
  localparam int PARCEL_W = 32;  // Delivered parcel width

  // Bit 0 clear marks an opcode fetch, no privilege bits
  localparam logic [2:0] PROT_INSTR = 3'b000;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  // One attribute region, set mask bits take part in the compare
  typedef struct packed {
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] mask;
    logic            exec;
  } pma_region_t;

  // Bus address phase
  typedef struct packed {
    logic [XLEN-1:0] adr;
    logic [2:0]      prot;
  } biu_req_t;

  // Entry of the parcel queue
  typedef struct packed {
    logic [XLEN-1:0]     pc;
    logic [PARCEL_W-1:0] parcel;
    logic                misaligned;
    logic                err;        // Attribute fault or bus error
  } parcel_t;

endpackage

// ==== source/imem_queue.sv ====
/*
 * Generic synchronous FIFO
 * Register array with read and write pointers and a fill count.
 * Payload type is a parameter, clr_i empties the queue.
 */

module imem_queue #(
  parameter type T           = logic [31:0],
  parameter int  DEPTH       = 2,
  parameter int  AFULL_LEVEL = DEPTH
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic clr_i,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  output T     data_o,
  output logic empty_o,
  output logic full_o,
  output logic afull_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] cnt;
  logic             wr_en;
  logic             rd_en;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign wr_en = push_i & ~full_o;   // Overflow is ignored
  assign rd_en = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clr_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (wr_en) wr_ptr <= ptr_inc(wr_ptr);
      if (rd_en) rd_ptr <= ptr_inc(rd_ptr);
      case ({wr_en, rd_en})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) mem[wr_ptr] <= data_i;
  end

  assign data_o  = mem[rd_ptr];
  assign empty_o = (cnt == '0);
  assign full_o  = (cnt == CNT_W'(DEPTH));
  assign afull_o = (cnt >= CNT_W'(AFULL_LEVEL));

endmodule

// ==== source/imem_pma_check.sv ====
/*
 * Fetch address attribute and alignment check
 * First matching region decides execute permission, an address
 * outside all regions faults. Alignment depends on RVC support.
 */

module imem_pma_check #(
  parameter int PMA_CNT = 4,
  parameter int HAS_RVC = 1
) (
  input  imem_pkg::pma_region_t [PMA_CNT-1:0] pma_cfg_i,
  input  logic [imem_pkg::XLEN-1:0]           adr_i,
  output logic                                pma_err_o,
  output logic                                misaligned_o
);

  logic hit;
  logic exec;

  ////////////////////////////////////////
  // Region match
  ////////////////////////////////////////

  always_comb begin
    hit  = 1'b0;
    exec = 1'b0;
    // Lowest index wins
    for (int i = 0; i < PMA_CNT; i++) begin
      if (!hit && ((adr_i ^ pma_cfg_i[i].base) & pma_cfg_i[i].mask) == '0) begin
        hit  = 1'b1;
        exec = pma_cfg_i[i].exec;
      end
    end
  end

  assign pma_err_o = ~hit | ~exec;  // No match counts as a fault

  ////////////////////////////////////////
  // Alignment
  ////////////////////////////////////////

  generate
    if (HAS_RVC != 0) begin : g_rvc
      assign misaligned_o = adr_i[0];  // 16 bit parcels
    end else begin : g_no_rvc
      assign misaligned_o = |adr_i[1:0];
    end
  endgenerate

endmodule

// ==== fetch/imem_fetch_seq.sv ====
/*
 * Fetch sequencer
 * Issues clean PCs as bus reads and tracks them in a pending queue.
 * Faulted PCs retire in order once no read is pending. Responses to
 * reads issued before a flush are counted off and discarded.
 */

module imem_fetch_seq #(
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      flush_i,
  input  logic [imem_pkg::XLEN-1:0] pc_head_i,
  input  logic                      pc_valid_i,
  input  logic                      pma_err_i,
  input  logic                      misaligned_i,
  output logic                      pc_pop_o,
  output logic                      biu_stb_o,
  output imem_pkg::biu_req_t        biu_req_o,
  input  logic                      biu_stb_ack_i,
  input  logic [imem_pkg::XLEN-1:0] biu_q_i,
  input  logic                      biu_ack_i,
  input  logic                      biu_err_i,
  output logic                      parcel_push_o,
  output imem_pkg::parcel_t         parcel_o
);
  import imem_pkg::*;

  localparam int CNT_W  = $clog2(MAX_OUTSTANDING + 1);
  localparam int DROP_W = CNT_W + 2;  // Headroom for back to back flushes

  logic              fault;
  logic              start;
  logic              adr_done;
  logic              issue;
  logic              stale_issue;
  logic              retire;
  logic              hold_vld;
  logic              hold_stale;
  logic [XLEN-1:0]   hold_adr;
  logic              resp;
  logic              keep_resp;
  logic              drop_resp;
  logic [CNT_W-1:0]  pend_cnt;
  logic [DROP_W-1:0] drop_cnt;
  logic [DROP_W-1:0] drop_nxt;
  parcel_t           pend_d;
  parcel_t           pend_q;
  logic              pend_empty;
  logic              pend_full;

  ////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////

  assign fault = pma_err_i | misaligned_i;
  assign start = pc_valid_i & ~fault & ~pend_full & ~hold_vld;

  // Once raised the strobe is held until acknowledged
  assign biu_stb_o      = hold_vld | start;
  assign biu_req_o.adr  = hold_vld ? hold_adr : pc_head_i;
  assign biu_req_o.prot = PROT_INSTR;

  assign adr_done    = biu_stb_o & biu_stb_ack_i;
  assign stale_issue = adr_done & ((hold_vld & hold_stale) | flush_i);
  assign issue       = adr_done & ~stale_issue;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      hold_vld   <= 1'b0;
      hold_stale <= 1'b0;
    end else if (adr_done) begin
      hold_vld   <= 1'b0;
      hold_stale <= 1'b0;
    end else if (biu_stb_o) begin
      hold_vld   <= 1'b1;
      hold_stale <= (hold_vld & hold_stale) | flush_i;  // Flushed while waiting
    end
  end

  always_ff @(posedge clk_i) begin
    if (biu_stb_o && !hold_vld) hold_adr <= pc_head_i;
  end

  ////////////////////////////////////////
  // Responses and retirement
  ////////////////////////////////////////

  assign resp      = biu_ack_i | biu_err_i;
  assign drop_resp = resp & (drop_cnt != '0);
  assign keep_resp = resp & ~drop_resp;

  // Faulted PC waits behind older reads
  assign retire   = pc_valid_i & fault & pend_empty & ~resp;
  assign pc_pop_o = issue | retire;

  assign pend_d = '{pc: biu_req_o.adr, parcel: '0, misaligned: 1'b0, err: 1'b0};

  imem_queue #(
    .T           (parcel_t),
    .DEPTH       (MAX_OUTSTANDING),
    .AFULL_LEVEL (MAX_OUTSTANDING)
  ) u_pending_queue (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .clr_i   (flush_i),
    .push_i  (issue),
    .data_i  (pend_d),
    .pop_i   (keep_resp),
    .data_o  (pend_q),
    .empty_o (pend_empty),
    .full_o  (pend_full),
    .afull_o ()
  );

  always_comb begin
    parcel_o = pend_q;
    if (retire) begin
      parcel_o.pc         = pc_head_i;
      parcel_o.parcel     = '0;
      parcel_o.misaligned = misaligned_i;
      parcel_o.err        = pma_err_i;
    end else begin
      // Upper halfword for pc bit 1
      parcel_o.parcel = PARCEL_W'(biu_q_i >> (16 * pend_q.pc[1]));
      parcel_o.err    = biu_err_i;
    end
  end

  assign parcel_push_o = keep_resp | retire;

  ////////////////////////////////////////
  // Outstanding and drop counters
  ////////////////////////////////////////

  always_comb begin
    drop_nxt = drop_cnt;
    if (drop_resp) drop_nxt = drop_nxt - 1'b1;
    if (stale_issue) drop_nxt = drop_nxt + 1'b1;
    if (flush_i) drop_nxt = drop_nxt + DROP_W'(pend_cnt) - DROP_W'(keep_resp);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_cnt <= '0;
      drop_cnt <= '0;
    end else begin
      drop_cnt <= drop_nxt;
      if (flush_i) begin
        pend_cnt <= '0;  // All of them move to the drop count
      end else begin
        pend_cnt <= pend_cnt + CNT_W'(issue) - CNT_W'(keep_resp);
      end
    end
  end

endmodule

// ==== source/imem_ctrl_top.sv ====
/*
 * Instruction memory controller, uncached fetch path
 * PC queue, attribute check, fetch sequencer on the external bus
 * and the parcel queue towards the CPU
 */

module imem_ctrl_top #(
  parameter int PMA_CNT         = 4,
  parameter int HAS_RVC         = 1,
  parameter int PC_DEPTH        = 2,
  parameter int MAX_OUTSTANDING = 4,
  parameter int PARCEL_DEPTH    = 8
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  imem_pkg::pma_region_t [PMA_CNT-1:0] pma_cfg_i,
  input  logic [imem_pkg::XLEN-1:0]           nxt_pc_i,
  output logic                                stall_nxt_pc_o,
  input  logic                                stall_i,
  input  logic                                flush_i,
  input  logic                                dcflush_rdy_i,
  output logic                                biu_stb_o,
  output imem_pkg::biu_req_t                  biu_req_o,
  input  logic                                biu_stb_ack_i,
  input  logic [imem_pkg::XLEN-1:0]           biu_q_i,
  input  logic                                biu_ack_i,
  input  logic                                biu_err_i,
  output logic                                parcel_valid_o,
  output imem_pkg::parcel_t                   parcel_o
);
  import imem_pkg::*;

  logic [XLEN-1:0] pc_head;
  logic            pc_empty;
  logic            pc_full;
  logic            pc_valid;
  logic            pc_pop;
  logic            pma_err;
  logic            misaligned;
  logic            parcel_push;
  parcel_t         parcel_d;
  logic            parcel_empty;
  logic            parcel_afull;

  // Hold new PCs on full queues or a pending data cache flush
  assign stall_nxt_pc_o = pc_full | parcel_afull | ~dcflush_rdy_i;

  imem_queue #(
    .T           (logic [XLEN-1:0]),
    .DEPTH       (PC_DEPTH),
    .AFULL_LEVEL (PC_DEPTH)
  ) u_pc_queue (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .clr_i   (flush_i),
    .push_i  (~stall_nxt_pc_o),
    .data_i  (nxt_pc_i),
    .pop_i   (pc_pop),
    .data_o  (pc_head),
    .empty_o (pc_empty),
    .full_o  (pc_full),
    .afull_o ()
  );

  // No new fetch starts while the parcel queue is nearly full,
  // so parcels plus reads in flight never exceed its depth
  assign pc_valid = ~pc_empty & ~parcel_afull;

  imem_pma_check #(
    .PMA_CNT (PMA_CNT),
    .HAS_RVC (HAS_RVC)
  ) u_pma_check (
    .pma_cfg_i    (pma_cfg_i),
    .adr_i        (pc_head),
    .pma_err_o    (pma_err),
    .misaligned_o (misaligned)
  );

  imem_fetch_seq #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_fetch_seq (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .pc_head_i     (pc_head),
    .pc_valid_i    (pc_valid),
    .pma_err_i     (pma_err),
    .misaligned_i  (misaligned),
    .pc_pop_o      (pc_pop),
    .biu_stb_o     (biu_stb_o),
    .biu_req_o     (biu_req_o),
    .biu_stb_ack_i (biu_stb_ack_i),
    .biu_q_i       (biu_q_i),
    .biu_ack_i     (biu_ack_i),
    .biu_err_i     (biu_err_i),
    .parcel_push_o (parcel_push),
    .parcel_o      (parcel_d)
  );

  imem_queue #(
    .T           (parcel_t),
    .DEPTH       (PARCEL_DEPTH),
    .AFULL_LEVEL (PARCEL_DEPTH - MAX_OUTSTANDING)  // Room for reads in flight
  ) u_parcel_queue (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .clr_i   (flush_i),
    .push_i  (parcel_push),
    .data_i  (parcel_d),
    .pop_i   (parcel_valid_o & ~stall_i),
    .data_o  (parcel_o),
    .empty_o (parcel_empty),
    .full_o  (),
    .afull_o (parcel_afull)
  );

  assign parcel_valid_o = ~parcel_empty;

endmodule

// ==== dv/imem_assertions.sv ====
/*
 * Protocol checks on the controller top level ports
 * Idle after reset, stable address phase, no fetch from region 1
 */

module imem_assertions (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic                  stb_i,
  input logic                  stb_ack_i,
  input imem_pkg::biu_req_t    req_i,
  input logic                  parcel_valid_i,
  input imem_pkg::pma_region_t region1_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;

  reset_idle: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !stb_i && !parcel_valid_i)
    else begin
      fail_cnt++;
      $error("strobe or parcel valid high right after reset");
    end

  // Address phase held until acknowledged
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stb_i && !stb_ack_i |=> stb_i && $stable(req_i))
    else begin
      fail_cnt++;
      $error("bus request changed while waiting for acknowledge");
    end

  no_region1: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stb_i |-> ((req_i.adr ^ region1_i.base) & region1_i.mask) != '0)
    else begin
      fail_cnt++;
      $error("bus read issued for non-executable address %h", req_i.adr);
    end

endmodule

bind imem_ctrl_top imem_assertions u_assertions (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .stb_i          (biu_stb_o),
  .stb_ack_i      (biu_stb_ack_i),
  .req_i          (biu_req_o),
  .parcel_valid_i (parcel_valid_o),
  .region1_i      (pma_cfg_i[1])
);

// ==== dv/imem_tb.sv ====
/*
 * Testbench for the instruction memory controller fetch path
 * Drives PC streams, models the external bus and checks every
 * delivered parcel against a reference model of the fetch rules
 */

module imem_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import imem_pkg::*;

  localparam int CYCLE_LIMIT = 4000;  // Twice the length of all six tests
  localparam int CHK_W       = $bits(parcel_t);  // Widest value under check

  typedef struct packed {
    logic [XLEN-1:0] adr;
    logic [31:0]     due;   // Cycle from which the answer may be driven
  } bus_rsp_t;

  logic                        clk_i;
  logic                        rst_n_i;
  pma_region_t [3:0]           pma_cfg_i;
  logic [XLEN-1:0]             nxt_pc_i;
  logic                        stall_nxt_pc_o;
  logic                        stall_i;
  logic                        flush_i;
  logic                        dcflush_rdy_i;
  logic                        biu_stb_o;
  biu_req_t                    biu_req_o;
  logic                        biu_stb_ack_i;
  logic [XLEN-1:0]             biu_q_i;
  logic                        biu_ack_i;
  logic                        biu_err_i;
  logic                        parcel_valid_o;
  parcel_t                     parcel_o;

  integer          seed = 32'hce3ab3ac;
  int              cyc = 0;
  int              err_cnt = 0;
  int              check_cnt = 0;
  string           cur_test = "reset";
  logic [XLEN-1:0] pc_list[$];
  parcel_t         exp_q[$];
  bus_rsp_t        rsp_q[$];

  imem_ctrl_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  function automatic int rand_below(input int n);
    return {$random(seed)} % n;
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic parcel_t expected_parcel(input logic [XLEN-1:0] pc);
    parcel_t         p;
    logic [XLEN-1:0] word;
    logic            fault;
    fault        = (pc[31:12] != 20'h0);  // Only region 0 may execute
    word         = {pc[31:2], 2'b00};
    p.pc         = pc;
    p.parcel     = '0;
    p.misaligned = pc[0];
    p.err        = fault;
    if (!fault && !pc[0]) begin
      if (word >= 32'h0F00 && word <= 32'h0FFC) begin
        p.err = 1'b1;                       // Bus error window
      end else begin
        p.parcel = (word ^ 32'h5A5A_0000) >> (pc[1] ? 16 : 0);
      end
    end
    return p;
  endfunction

  task automatic check_value(input string name, input logic [CHK_W-1:0] exp,
                             input logic [CHK_W-1:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // Bus model
  ////////////////////////////////////////

  initial begin : bus_model
    int       stb_wait;
    bus_rsp_t rsp;
    stb_wait      = -1;
    biu_stb_ack_i = 1'b0;
    biu_ack_i     = 1'b0;
    biu_err_i     = 1'b0;
    biu_q_i       = '0;
    forever begin
      @(negedge clk_i);
      biu_stb_ack_i = 1'b0;
      biu_ack_i     = 1'b0;
      biu_err_i     = 1'b0;
      biu_q_i       = '0;
      if (rst_n_i) begin
        // Data phases strictly in order
        if (rsp_q.size() > 0 && rsp_q[0].due <= cyc) begin
          rsp     = rsp_q.pop_front();
          rsp.adr = {rsp.adr[31:2], 2'b00};
          if (rsp.adr >= 32'h0F00 && rsp.adr <= 32'h0FFC) begin
            biu_err_i = 1'b1;
          end else begin
            biu_ack_i = 1'b1;
            biu_q_i   = rsp.adr ^ 32'h5A5A_0000;
          end
        end
        if (biu_stb_o) begin
          if (stb_wait < 0) stb_wait = rand_below(4);
          if (stb_wait == 0) begin
            biu_stb_ack_i = 1'b1;
            check_value($sformatf("%s prot", cur_test), CHK_W'(PROT_INSTR),
                        CHK_W'(biu_req_o.prot));
            rsp_q.push_back('{adr: biu_req_o.adr, due: cyc + 1 + rand_below(4)});
            stb_wait = -1;
          end else begin
            stb_wait--;
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // Comparison of consumed parcels
  ////////////////////////////////////////

  initial begin : compare
    parcel_t exp_p;
    forever begin
      @(negedge clk_i);
      #1;  // Inputs of this cycle have settled
      if (rst_n_i && parcel_valid_o && !stall_i) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("ERROR: %s delivered a parcel for pc %h that was never expected",
                   cur_test, parcel_o.pc);
        end else begin
          exp_p = exp_q.pop_front();
          check_cnt++;
          check_value($sformatf("%s pc %h", cur_test, exp_p.pc), exp_p, parcel_o);
        end
      end
    end
  end

  initial begin : watchdog
    wait (cyc >= CYCLE_LIMIT);
    $display("ERROR: cycle limit of %0d reached before all parcels arrived", CYCLE_LIMIT);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic run_stream(input bit rand_mode, input int flush_at);
    int idx;
    bit flushed;
    bit in_flight;
    idx     = 0;
    flushed = 1'b0;
    while (idx < pc_list.size()) begin
      in_flight = (rsp_q.size() > 0);  // Acked reads not yet answered
      @(negedge clk_i);
      if (flush_at >= 0 && !flushed && idx >= flush_at && in_flight) begin
        flush_i       = 1'b1;               // Reads are in flight
        stall_i       = 1'b1;
        dcflush_rdy_i = 1'b0;
        flushed       = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        stall_i = 1'b0;
        exp_q.delete();
      end else begin
        stall_i       = rand_mode ? (rand_below(2) == 1) : 1'b0;
        dcflush_rdy_i = rand_mode ? (rand_below(4) != 0) : 1'b1;
        nxt_pc_i      = pc_list[idx];
        #1;
        if (!dcflush_rdy_i) begin
          check_value($sformatf("%s stall", cur_test), CHK_W'(1'b1),
                      CHK_W'(stall_nxt_pc_o));
        end
        if (!stall_nxt_pc_o) begin
          exp_q.push_back(expected_parcel(pc_list[idx]));
          idx++;
        end
      end
    end
    if (flush_at >= 0 && !flushed) begin
      err_cnt++;
      $display("ERROR: %s never saw a read in flight to flush", cur_test);
    end
  endtask

  // Low dcflush_rdy_i keeps further PCs out while the queues empty
  task automatic drain(input bit rand_mode);
    do begin
      @(negedge clk_i);
      dcflush_rdy_i = 1'b0;
      stall_i       = rand_mode ? (rand_below(2) == 1) : 1'b0;
      #1;
    end while (exp_q.size() > 0 || rsp_q.size() > 0 || biu_stb_o || parcel_valid_o);
    stall_i = 1'b0;
  endtask

  task automatic run_test(input string name, input bit rand_mode, input int flush_at);
    int err_before;
    int chk_before;
    err_before = err_cnt;
    chk_before = check_cnt;
    cur_test   = name;
    run_stream(rand_mode, flush_at);
    drain(rand_mode);
    if (err_cnt == err_before) begin
      $display("%s: ok, %0d parcels", name, check_cnt - chk_before);
    end else begin
      $display("%s: %0d errors", name, err_cnt - err_before);
    end
    pc_list.delete();
  endtask

  initial begin : main
    rst_n_i       = 1'b0;
    nxt_pc_i      = '0;
    stall_i       = 1'b0;
    flush_i       = 1'b0;
    dcflush_rdy_i = 1'b0;
    pma_cfg_i[0]  = '{base: 32'h0000_0000, mask: 32'hFFFF_F000, exec: 1'b1};
    pma_cfg_i[1]  = '{base: 32'h0000_1000, mask: 32'hFFFF_F000, exec: 1'b0};
    pma_cfg_i[2]  = '{base: 32'hFFFF_FFF0, mask: 32'hFFFF_FFFF, exec: 1'b0};
    pma_cfg_i[3]  = '{base: 32'hFFFF_FFF4, mask: 32'hFFFF_FFFF, exec: 1'b0};
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    for (int i = 0; i < 64; i++) pc_list.push_back(32'h200 + 2 * i);
    run_test("sequential", 1'b0, -1);

    for (int i = 0; i < 64; i++) pc_list.push_back(2 * rand_below(32'h780));
    run_test("random_stall", 1'b1, -1);

    for (int i = 0; i < 16; i++) begin
      case (i % 4)
        0:       pc_list.push_back(32'h0400 + 4 * i);
        1:       pc_list.push_back(32'h1000 + 4 * i);     // Not executable
        2:       pc_list.push_back(32'h4000_0000 + 4 * i); // Outside all regions
        default: pc_list.push_back(32'h0402 + 4 * i);
      endcase
    end
    run_test("pma_fault", 1'b0, -1);

    for (int i = 0; i < 16; i++) pc_list.push_back(32'h500 + 4 * i + (i % 2));
    pc_list.push_back(32'h1003);
    run_test("misaligned", 1'b0, -1);

    for (int i = 0; i < 16; i++) begin
      pc_list.push_back((i % 2) ? 32'h600 + 2 * i : 32'hF00 + 8 * i);
    end
    run_test("bus_error", 1'b0, -1);

    for (int i = 0; i < 32; i++) pc_list.push_back(32'h700 + 2 * i);
    run_test("flush", 1'b0, 10);

    err_cnt += u_dut.u_assertions.fail_cnt;
    $display("6 tests run, %0d parcels checked, %0d assertion failures, %0d errors",
             check_cnt, u_dut.u_assertions.fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
common/imem_pkg.sv
source/imem_queue.sv
source/imem_pma_check.sv
fetch/imem_fetch_seq.sv
source/imem_ctrl_top.sv
dv/imem_assertions.sv
dv/imem_tb.sv

// ==== Makefile ====
# Verilator build and run of the instruction fetch path testbench

VERILATOR ?= verilator
TOP       ?= imem_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
